// ==== stq_entry.f ====
common/lsu_tag_pkg.sv
common/stq_entry_pkg.sv
design/stq_entry/stq_addr_capture.sv
design/stq_entry/stq_rob_monitor.sv
design/stq_entry/stq_operand_track.sv
design/stq_entry/stq_entry_ctrl.sv
design/stq_entry/stq_entry.sv
verif/stq_clk_gen.sv
verif/stq_entry_chk.sv
verif/stq_entry_tb.sv

// ==== Bender.yml ====
package:
  name: stq_entry

sources:
  - files:
      - common/lsu_tag_pkg.sv
      - common/stq_entry_pkg.sv
      - design/stq_entry/stq_addr_capture.sv
      - design/stq_entry/stq_rob_monitor.sv
      - design/stq_entry/stq_operand_track.sv
      - design/stq_entry/stq_entry_ctrl.sv
      - design/stq_entry/stq_entry.sv
  - target: simulation
    files:
      - verif/stq_clk_gen.sv
      - verif/stq_entry_chk.sv
      - verif/stq_entry_tb.sv

// ==== verif/stq_entry_tb.sv ====
// ---------------------------------------------------------------------
// testbench for one store-queue entry from dispatch through write-out
// ---------------------------------------------------------------------

module stq_entry_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import lsu_tag_pkg::*;
  import stq_entry_pkg::*;

  localparam int N_TESTS     = 6;
  localparam int TEST_CYCLES = 200;
  localparam int CLK_PERIOD  = 100;
  localparam int READY_LIMIT = 50;
  localparam int DRAIN_LIMIT = 100;
  localparam logic [1:0] KIND_NONE  = 2'd0;
  localparam logic [1:0] KIND_STBUF = 2'd1;
  localparam logic [1:0] KIND_UC    = 2'd2;

  logic     i_clk;
  logic     i_reset_n;
  logic     i_disp_load;
  cmt_id_t  i_disp_cmt_id;
  grp_id_t  i_disp_grp_id;
  brmask_t  i_disp_br_mask;
  rnid_t    i_disp_rs1_rnid;
  rnid_t    i_disp_rs2_rnid;
  logic     i_disp_rs1_ready;
  logic     i_disp_rs2_ready;
  data_t    i_disp_rs2_data;
  logic     i_phy_wr_valid;
  rnid_t    i_phy_wr_rnid;
  data_t    i_phy_wr_data;
  logic     i_entry_picked;
  logic     i_ex1_valid;
  ex1_haz_e i_ex1_haz;
  addr_t    i_ex1_vaddr;
  addr_t    i_ex1_paddr;
  st_size_t i_ex1_size;
  logic     i_ex1_uc;
  logic     i_ex1_except;
  logic     i_br_update;
  brtag_t   i_br_tag;
  logic     i_br_mispredict;
  logic     i_commit_valid;
  cmt_id_t  i_commit_cmt_id;
  grp_id_t  i_commit_done_grp;
  logic     i_commit_flush;
  logic     i_stbuf_accept;
  logic     i_uc_write_accept;
  logic     i_stq_outptr_valid;
  logic     o_entry_ready;
  logic     o_stbuf_req_valid;
  logic     o_uc_write_req_valid;
  addr_t    o_st_addr;
  st_size_t o_st_size;
  data_t    o_st_data;
  logic     o_st_finish;

  // expected results of the running test
  logic [1:0] exp_kind;
  addr_t      exp_addr;
  st_size_t   exp_size;
  data_t      exp_data;
  logic       exp_killed;
  logic       rs2_pending;
  logic [1:0] got_kind;
  logic       fin_seen;
  logic       req_prev;
  logic       acc_prev;
  string      test_name;
  int         errors;
  int         test_errors;
  int         tests_done;
  int         tests_failed;
  int         chk_fails;

  stq_clk_gen u_clk_gen (.o_clk(i_clk), .o_reset_n(i_reset_n));

  stq_entry i_stq_entry (.*);

  bind stq_entry_ctrl stq_entry_chk u_chk (
    .i_clk, .i_reset_n, .i_state(o_state), .i_stbuf_req_valid(o_stbuf_req_valid),
    .i_uc_write_req_valid(o_uc_write_req_valid), .i_stbuf_accept, .i_uc_write_accept,
    .i_st_finish(o_st_finish)
  );

  function automatic void report_error(input string msg);
    errors++;
    test_errors++;
    $display("%s", msg);
  endfunction

  // expected outcome of one store from its stimulus
  function automatic void stq_ref_expect(
    input addr_t vaddr, input addr_t paddr, input st_size_t size, input logic uc,
    input logic except, input logic rs2_from_bus, input data_t disp_data,
    input data_t bus_data, input brmask_t mask, input brtag_t tag, input logic early_ok,
    input logic misp, output logic [1:0] kind, output addr_t addr, output st_size_t sz,
    output data_t data, output logic killed);
    brmask_t live_mask;
    live_mask = mask;
    // a correct resolution drops the tag before any later mispredict
    if (early_ok) begin
      live_mask[tag] = 1'b0;
    end
    killed = misp && live_mask[tag];
    if (killed || except) begin
      kind = KIND_NONE;
    end else begin
      kind = uc ? KIND_UC : KIND_STBUF;
    end
    addr = except ? vaddr : paddr;
    sz   = size;
    data = rs2_from_bus ? bus_data : disp_data;
  endfunction

  // ---------------------------------------------------------------------
  // stimulus tasks
  // ---------------------------------------------------------------------
  task automatic bus_write(input rnid_t rnid, input data_t data);
    @(posedge i_clk);
    i_phy_wr_valid <= 1'b1;
    i_phy_wr_rnid  <= rnid;
    i_phy_wr_data  <= data;
    @(posedge i_clk);
    i_phy_wr_valid <= 1'b0;
  endtask

  task automatic resolve_branch(input brtag_t tag, input logic misp);
    @(posedge i_clk);
    i_br_update     <= 1'b1;
    i_br_tag        <= tag;
    i_br_mispredict <= misp;
    @(posedge i_clk);
    i_br_update     <= 1'b0;
    i_br_mispredict <= 1'b0;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge i_clk);
    while (!o_entry_ready && n < READY_LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_entry_ready) begin
      report_error("entry never became ready for issue");
    end
  endtask

  task automatic issue_once(input ex1_haz_e haz, input addr_t vaddr, input addr_t paddr,
                            input st_size_t size, input logic uc, input logic except);
    wait_ready();
    @(posedge i_clk);
    i_entry_picked <= 1'b1;
    @(posedge i_clk);
    i_entry_picked <= 1'b0;
    i_ex1_valid    <= 1'b1;
    i_ex1_haz      <= haz;
    i_ex1_vaddr    <= vaddr;
    i_ex1_paddr    <= paddr;
    i_ex1_size     <= size;
    i_ex1_uc       <= uc;
    i_ex1_except   <= except;
    @(posedge i_clk);
    i_ex1_valid <= 1'b0;
  endtask

  // hold the head pointer until finish and accept after acc_delay request cycles
  task automatic drain_finish(input int acc_delay);
    int   req_cycles;
    int   n;
    logic done;
    req_cycles = 0;
    n = 0;
    done = 1'b0;
    while (!done && n < DRAIN_LIMIT) begin
      @(negedge i_clk);
      n++;
      if (o_st_finish) begin
        done = 1'b1;
      end else if (o_stbuf_req_valid || o_uc_write_req_valid) begin
        req_cycles++;
      end
      @(posedge i_clk);
      if (done) begin
        i_stbuf_accept    <= 1'b0;
        i_uc_write_accept <= 1'b0;
      end else if (req_cycles > acc_delay) begin
        i_stbuf_accept    <= 1'b1;
        i_uc_write_accept <= 1'b1;
      end
    end
    if (!done) begin
      report_error($sformatf("no o_st_finish within %0d cycles", DRAIN_LIMIT));
    end
    // head pointer stays one more cycle so a repeated finish would show
    @(posedge i_clk);
    i_stq_outptr_valid <= 1'b0;
    i_stbuf_accept     <= 1'b0;
    i_uc_write_accept  <= 1'b0;
  endtask

  task automatic run_store(input string name, input logic rs1_rdy, input logic rs2_rdy,
                           input logic haz_first, input logic uc, input logic except,
                           input int acc_delay, input logic early_ok, input logic misp);
    rnid_t    rs1_id;
    rnid_t    rs2_id;
    cmt_id_t  cmt;
    data_t    disp_data;
    data_t    bus_data;
    addr_t    vaddr;
    addr_t    paddr;
    st_size_t size;
    brtag_t   tag;
    brmask_t  mask;
    rs1_id    = rnid_t'($urandom());
    rs2_id    = rs1_id ^ rnid_t'(1);
    cmt       = cmt_id_t'($urandom());
    disp_data = {$urandom(), $urandom()};
    bus_data  = {$urandom(), $urandom()};
    vaddr     = addr_t'({$urandom(), $urandom()});
    paddr     = addr_t'({$urandom(), $urandom()});
    size      = st_size_t'($urandom());
    tag       = brtag_t'($urandom());
    mask      = brmask_t'($urandom()) | (brmask_t'(1) << tag);
    stq_ref_expect(vaddr, paddr, size, uc, except, !rs2_rdy, disp_data, bus_data, mask, tag,
                   early_ok, misp, exp_kind, exp_addr, exp_size, exp_data, exp_killed);
    test_name   = name;
    test_errors = 0;
    got_kind    = KIND_NONE;
    fin_seen    = 1'b0;
    rs2_pending = !rs2_rdy;
    @(posedge i_clk);
    i_disp_load      <= 1'b1;
    i_disp_cmt_id    <= cmt;
    i_disp_grp_id    <= grp_id_t'(1) << ($urandom() % GRP_W);
    i_disp_br_mask   <= mask;
    i_disp_rs1_rnid  <= rs1_id;
    i_disp_rs2_rnid  <= rs2_id;
    i_disp_rs1_ready <= rs1_rdy;
    i_disp_rs2_ready <= rs2_rdy;
    i_disp_rs2_data  <= disp_data;
    @(posedge i_clk);
    i_disp_load <= 1'b0;
    if (early_ok) begin
      resolve_branch(tag, 1'b0);
    end
    if (misp) begin
      resolve_branch(tag, 1'b1);
    end
    if (exp_killed) begin
      @(posedge i_clk);
      i_stq_outptr_valid <= 1'b1;
    end else begin
      if (!rs1_rdy) begin
        // an unrelated write must leave the entry idle
        repeat (2) @(negedge i_clk);
        bus_write(rs1_id ^ rnid_t'(2), {$urandom(), $urandom()});
        @(negedge i_clk);
        if (o_entry_ready) begin
          report_error("o_entry_ready high before rs1 was written");
        end
        bus_write(rs1_id, {$urandom(), $urandom()});
      end
      if (haz_first) begin
        issue_once(HAZ_TLB_MISS, vaddr, paddr, size, uc, except);
      end
      issue_once(HAZ_NONE, vaddr, paddr, size, uc, except);
      @(posedge i_clk);
      i_commit_valid    <= 1'b1;
      i_commit_cmt_id   <= cmt;
      i_commit_done_grp <= '1;
      @(posedge i_clk);
      i_commit_valid     <= 1'b0;
      i_stq_outptr_valid <= 1'b1;
      if (!rs2_rdy) begin
        repeat (3) @(posedge i_clk);
        bus_write(rs2_id, bus_data);
        rs2_pending = 1'b0;
      end
    end
    drain_finish(acc_delay);
  endtask

  // ---------------------------------------------------------------------
  // comparing process sampled mid-cycle
  // ---------------------------------------------------------------------
  always @(negedge i_clk) begin : compare
    logic req_now;
    logic acc_now;
    req_now = o_stbuf_req_valid | o_uc_write_req_valid;
    acc_now = o_stbuf_req_valid & i_stbuf_accept | o_uc_write_req_valid & i_uc_write_accept;
    if (i_reset_n) begin
      if (req_now && (exp_kind == KIND_NONE || rs2_pending)) begin
        report_error("write request raised when none was expected yet");
      end
      if (req_prev && !acc_prev && !req_now) begin
        report_error("write request dropped while its accept was low");
      end
      if (acc_now) begin
        got_kind = o_stbuf_req_valid ? KIND_STBUF : KIND_UC;
        if (o_st_addr != exp_addr) begin
          report_error($sformatf("mismatch o_st_addr: got %h expected %h", o_st_addr, exp_addr));
        end
        if (o_st_size != exp_size) begin
          report_error($sformatf("mismatch o_st_size: got %h expected %h", o_st_size, exp_size));
        end
        if (o_st_data != exp_data) begin
          report_error($sformatf("mismatch o_st_data: got %h expected %h", o_st_data, exp_data));
        end
      end
      if (o_st_finish) begin
        if (fin_seen) begin
          report_error("second o_st_finish for one store");
        end
        if (got_kind != exp_kind) begin
          report_error($sformatf("mismatch request kind: got %h expected %h", got_kind, exp_kind));
        end
        if (exp_kind == KIND_NONE && !exp_killed && o_st_addr != exp_addr) begin
          report_error($sformatf("mismatch o_st_addr: got %h expected %h", o_st_addr, exp_addr));
        end
        fin_seen = 1'b1;
        tests_done++;
        if (test_errors != 0) begin
          tests_failed++;
        end
        $display("test %0d %s: %0d errors", tests_done, test_name, test_errors);
      end
    end
    req_prev = req_now;
    acc_prev = acc_now;
  end

  initial begin
    #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("watchdog expired before all tests completed");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(62));
    {i_disp_load, i_disp_cmt_id, i_disp_grp_id, i_disp_br_mask} = '0;
    {i_disp_rs1_rnid, i_disp_rs2_rnid, i_disp_rs1_ready, i_disp_rs2_ready} = '0;
    {i_disp_rs2_data, i_phy_wr_valid, i_phy_wr_rnid, i_phy_wr_data} = '0;
    {i_entry_picked, i_ex1_valid, i_ex1_vaddr, i_ex1_paddr, i_ex1_size} = '0;
    {i_ex1_uc, i_ex1_except, i_br_update, i_br_tag, i_br_mispredict} = '0;
    {i_commit_valid, i_commit_cmt_id, i_commit_done_grp, i_commit_flush} = '0;
    {i_stbuf_accept, i_uc_write_accept, i_stq_outptr_valid} = '0;
    i_ex1_haz = HAZ_NONE;
    {exp_kind, exp_killed, rs2_pending, got_kind, fin_seen, req_prev, acc_prev} = '0;
    errors = 0;
    tests_done = 0;
    tests_failed = 0;
    @(posedge i_reset_n);
    repeat (2) @(posedge i_clk);
    run_store("cacheable with operands ready", 1, 1, 0, 0, 0, 0, 0, 0);
    run_store("rs1 wakeup and ex1 hazard", 0, 1, 1, 0, 0, 0, 0, 0);
    run_store("rs2 from write bus, tag resolved then mispredicted", 1, 0, 0, 0, 0, 0, 1, 1);
    run_store("uncached under back-pressure", 1, 1, 0, 1, 0, 4, 0, 0);
    run_store("ex1 exception", 1, 1, 0, 0, 1, 0, 0, 0);
    run_store("mispredict kill", 1, 1, 0, 0, 0, 0, 0, 1);
    repeat (3) @(posedge i_clk);
    chk_fails = i_stq_entry.u_ctrl.u_chk.n_fail;
    $display("tests finished %0d of %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_done, N_TESTS, tests_failed, errors, chk_fails);
    if (errors == 0 && chk_fails == 0 && tests_done == N_TESTS) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/stq_entry_chk.sv ====
// ---------------------------------------------------------------------
// protocol assertions for the store-queue entry controller
// ---------------------------------------------------------------------

module stq_entry_chk (
  input logic                      i_clk,
  input logic                      i_reset_n,
  input stq_entry_pkg::stq_state_e i_state,
  input logic                      i_stbuf_req_valid,
  input logic                      i_uc_write_req_valid,
  input logic                      i_stbuf_accept,
  input logic                      i_uc_write_accept,
  input logic                      i_st_finish
);

  timeunit 1ns;
  timeprecision 1ps;

  import stq_entry_pkg::*;

  // number of failed assertions
  int n_fail = 0;

  a_one_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_stbuf_req_valid && i_uc_write_req_valid))
    else begin
      n_fail++;
      $error("store-buffer and uncached requests high together");
    end

  a_stbuf_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_stbuf_req_valid && !i_stbuf_accept |=> i_stbuf_req_valid)
    else begin
      n_fail++;
      $error("store-buffer request dropped before accept");
    end

  a_uc_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_uc_write_req_valid && !i_uc_write_accept |=> i_uc_write_req_valid)
    else begin
      n_fail++;
      $error("uncached write request dropped before accept");
    end

  // entry is free again right after it finishes
  a_finish_init: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_st_finish |=> i_state == ST_INIT)
    else begin
      n_fail++;
      $error("entry not in ST_INIT after finish");
    end

endmodule

// ==== verif/stq_clk_gen.sv ====
// ---------------------------------------------------------------------
// testbench clock and reset source, 100 ns period
// ---------------------------------------------------------------------

module stq_clk_gen (
  output logic o_clk,
  output logic o_reset_n
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 4;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // reset held low for the first few edges
  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset_n <= 1'b1;
  end

endmodule

// ==== design/stq_entry/stq_entry.sv ====
// ---------------------------------------------------------------------
// store-queue entry: one dispatched store from issue through commit
// ---------------------------------------------------------------------

module stq_entry (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  // dispatch
  input  logic                         i_disp_load,
  input  lsu_tag_pkg::cmt_id_t         i_disp_cmt_id,
  input  lsu_tag_pkg::grp_id_t         i_disp_grp_id,
  input  lsu_tag_pkg::brmask_t         i_disp_br_mask,
  input  lsu_tag_pkg::rnid_t           i_disp_rs1_rnid,
  input  lsu_tag_pkg::rnid_t           i_disp_rs2_rnid,
  input  logic                         i_disp_rs1_ready,
  input  logic                         i_disp_rs2_ready,
  input  lsu_tag_pkg::data_t           i_disp_rs2_data,
  // physical write bus
  input  logic                         i_phy_wr_valid,
  input  lsu_tag_pkg::rnid_t           i_phy_wr_rnid,
  input  lsu_tag_pkg::data_t           i_phy_wr_data,
  // issue and EX1
  input  logic                         i_entry_picked,
  input  logic                         i_ex1_valid,
  input  stq_entry_pkg::ex1_haz_e      i_ex1_haz,
  input  lsu_tag_pkg::addr_t           i_ex1_vaddr,
  input  lsu_tag_pkg::addr_t           i_ex1_paddr,
  input  stq_entry_pkg::st_size_t      i_ex1_size,
  input  logic                         i_ex1_uc,
  input  logic                         i_ex1_except,
  // branch resolution
  input  logic                         i_br_update,
  input  lsu_tag_pkg::brtag_t          i_br_tag,
  input  logic                         i_br_mispredict,
  // commit
  input  logic                         i_commit_valid,
  input  lsu_tag_pkg::cmt_id_t         i_commit_cmt_id,
  input  lsu_tag_pkg::grp_id_t         i_commit_done_grp,
  input  logic                         i_commit_flush,
  // write-out
  input  logic                         i_stbuf_accept,
  input  logic                         i_uc_write_accept,
  input  logic                         i_stq_outptr_valid,
  output logic                         o_entry_ready,
  output logic                         o_stbuf_req_valid,
  output logic                         o_uc_write_req_valid,
  output lsu_tag_pkg::addr_t           o_st_addr,
  output stq_entry_pkg::st_size_t      o_st_size,
  output lsu_tag_pkg::data_t           o_st_data,
  output logic                         o_st_finish
);

  import stq_entry_pkg::*;

  stq_state_e w_state;
  logic       w_flush;
  logic       w_disp_flush;
  logic       w_commit_ok;
  logic       w_rs1_ready;
  logic       w_rs2_held;
  logic       w_ex1_accept;
  logic       w_uc;
  logic       w_except;

  stq_entry_ctrl u_ctrl (
    .i_clk, .i_reset_n, .i_disp_load, .i_entry_picked, .i_ex1_valid, .i_ex1_haz,
    .i_flush (w_flush), .i_disp_flush (w_disp_flush), .i_commit_ok (w_commit_ok),
    .i_rs1_ready (w_rs1_ready), .i_rs2_held (w_rs2_held), .i_except (w_except),
    .i_uc (w_uc), .i_stbuf_accept, .i_uc_write_accept, .i_stq_outptr_valid,
    .o_state (w_state), .o_ex1_accept (w_ex1_accept), .o_entry_ready,
    .o_stbuf_req_valid, .o_uc_write_req_valid, .o_st_finish
  );

  stq_operand_track u_operand_track (
    .i_clk, .i_reset_n, .i_disp_load, .i_disp_rs1_rnid, .i_disp_rs2_rnid,
    .i_disp_rs1_ready, .i_disp_rs2_ready, .i_disp_rs2_data,
    .i_phy_wr_valid, .i_phy_wr_rnid, .i_phy_wr_data,
    .o_rs1_ready (w_rs1_ready), .o_rs2_held (w_rs2_held), .o_st_data
  );

  stq_rob_monitor u_rob_monitor (
    .i_clk, .i_reset_n, .i_disp_load, .i_disp_cmt_id, .i_disp_grp_id, .i_disp_br_mask,
    .i_br_update, .i_br_tag, .i_br_mispredict, .i_commit_valid, .i_commit_cmt_id,
    .i_commit_done_grp, .i_commit_flush, .i_state (w_state),
    .o_flush (w_flush), .o_disp_flush (w_disp_flush), .o_commit_ok (w_commit_ok)
  );

  stq_addr_capture u_addr_capture (
    .i_clk, .i_reset_n, .i_ex1_accept (w_ex1_accept), .i_ex1_vaddr, .i_ex1_paddr,
    .i_ex1_size, .i_ex1_uc, .i_ex1_except,
    .o_st_addr, .o_st_size, .o_uc (w_uc), .o_except (w_except)
  );

endmodule

// ==== design/stq_entry/stq_entry_ctrl.sv ====
// ---------------------------------------------------------------------
// store-queue entry FSM with issue request, write requests and finish
// ---------------------------------------------------------------------

module stq_entry_ctrl (
  input  logic                             i_clk,
  input  logic                             i_reset_n,
  input  logic                             i_disp_load,
  input  logic                             i_entry_picked,
  input  logic                             i_ex1_valid,
  input  stq_entry_pkg::ex1_haz_e          i_ex1_haz,
  input  logic                             i_flush,
  input  logic                             i_disp_flush,
  input  logic                             i_commit_ok,
  input  logic                             i_rs1_ready,
  input  logic                             i_rs2_held,
  input  logic                             i_except,
  input  logic                             i_uc,
  input  logic                             i_stbuf_accept,
  input  logic                             i_uc_write_accept,
  input  logic                             i_stq_outptr_valid,
  output stq_entry_pkg::stq_state_e        o_state,
  output logic                             o_ex1_accept,
  output logic                             o_entry_ready,
  output logic                             o_stbuf_req_valid,
  output logic                             o_uc_write_req_valid,
  output logic                             o_st_finish
);

  import stq_entry_pkg::*;

  stq_state_e r_state;
  stq_state_e w_state_next;
  logic       w_in_commit;
  logic       w_req_done;

  // ---------------------------------------------------------------------
  // issue side
  // ---------------------------------------------------------------------

  // address operand present and no kill this cycle
  assign o_entry_ready = (r_state == ST_ISSUE_WAIT) & i_rs1_ready & ~i_flush;

  // clean EX1 result loads the address fields
  assign o_ex1_accept = (r_state == ST_ISSUED) & i_ex1_valid &
                        (i_ex1_haz == HAZ_NONE) & ~i_flush;

  // ---------------------------------------------------------------------
  // write-out side
  // ---------------------------------------------------------------------

  // only the queue head talks to the store buffer
  assign w_in_commit = (r_state == ST_COMMIT) & i_stq_outptr_valid;

  assign o_stbuf_req_valid    = w_in_commit & ~i_uc & ~i_except;
  assign o_uc_write_req_valid = w_in_commit &  i_uc & ~i_except;

  assign w_req_done = o_stbuf_req_valid    & i_stbuf_accept |
                      o_uc_write_req_valid & i_uc_write_accept;

  // faulting stores retire without a write
  assign o_st_finish = w_in_commit & (w_req_done | i_except) |
                       (r_state == ST_DEAD) & i_stq_outptr_valid;

  // ---------------------------------------------------------------------
  // state transitions
  // ---------------------------------------------------------------------
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      ST_INIT: begin
        if (i_disp_load) begin
          w_state_next = i_disp_flush ? ST_DEAD : ST_ISSUE_WAIT;
        end
      end
      ST_ISSUE_WAIT: begin
        if (i_flush) begin
          w_state_next = ST_DEAD;
        end else if (o_entry_ready & i_entry_picked) begin
          w_state_next = ST_ISSUED;
        end
      end
      ST_ISSUED: begin
        if (i_flush) begin
          w_state_next = ST_DEAD;
        end else if (i_ex1_valid) begin
          // any hazard sends the store back for another pick
          w_state_next = (i_ex1_haz == HAZ_NONE) ? ST_WAIT_COMMIT : ST_ISSUE_WAIT;
        end
      end
      ST_WAIT_COMMIT: begin
        if (i_flush) begin
          w_state_next = ST_DEAD;
        end else if (i_commit_ok) begin
          w_state_next = i_rs2_held ? ST_COMMIT : ST_WAIT_ST_DATA;
        end
      end
      ST_WAIT_ST_DATA: begin
        if (i_flush) begin
          w_state_next = ST_DEAD;
        end else if (i_rs2_held) begin
          w_state_next = ST_COMMIT;
        end
      end
      ST_COMMIT: begin
        if (o_st_finish) begin
          w_state_next = ST_INIT;
        end
      end
      ST_DEAD: begin
        // wait for the head pointer so the queue drains in order
        if (i_stq_outptr_valid) begin
          w_state_next = ST_INIT;
        end
      end
      default: begin
        w_state_next = ST_INIT;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_INIT;
    end else begin
      r_state <= w_state_next;
    end
  end

  assign o_state = r_state;

endmodule

// ==== design/stq_entry/stq_operand_track.sv ====
// ---------------------------------------------------------------------
// operand tracking: rs1 readiness and rs2 store data capture
// ---------------------------------------------------------------------

module stq_operand_track (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_disp_load,
  input  lsu_tag_pkg::rnid_t    i_disp_rs1_rnid,
  input  lsu_tag_pkg::rnid_t    i_disp_rs2_rnid,
  input  logic                  i_disp_rs1_ready,
  input  logic                  i_disp_rs2_ready,
  input  lsu_tag_pkg::data_t    i_disp_rs2_data,
  input  logic                  i_phy_wr_valid,
  input  lsu_tag_pkg::rnid_t    i_phy_wr_rnid,
  input  lsu_tag_pkg::data_t    i_phy_wr_data,
  output logic                  o_rs1_ready,
  output logic                  o_rs2_held,
  output lsu_tag_pkg::data_t    o_st_data
);

  import lsu_tag_pkg::*;

  rnid_t r_rs1_rnid;
  rnid_t r_rs2_rnid;
  data_t r_rs2_data;
  logic  r_rs1_ready;
  logic  r_rs2_held;
  logic  w_rs1_hit;
  logic  w_rs2_hit;
  logic  w_rs2_held_now;

  // compare against the incoming ids in the dispatch cycle
  assign w_rs1_hit = i_phy_wr_valid &
                     (i_phy_wr_rnid == (i_disp_load ? i_disp_rs1_rnid : r_rs1_rnid));
  assign w_rs2_hit = i_phy_wr_valid &
                     (i_phy_wr_rnid == (i_disp_load ? i_disp_rs2_rnid : r_rs2_rnid));

  assign w_rs2_held_now = i_disp_load ? i_disp_rs2_ready : r_rs2_held;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rs1_ready <= 1'b0;
      r_rs2_held  <= 1'b0;
    end else begin
      r_rs1_ready <= (i_disp_load ? i_disp_rs1_ready : r_rs1_ready) | w_rs1_hit;
      r_rs2_held  <= w_rs2_held_now | w_rs2_hit;
    end
  end

  // ids and store data
  always_ff @(posedge i_clk) begin
    if (i_disp_load) begin
      r_rs1_rnid <= i_disp_rs1_rnid;
      r_rs2_rnid <= i_disp_rs2_rnid;
    end
    if (w_rs2_held_now) begin
      if (i_disp_load) begin
        r_rs2_data <= i_disp_rs2_data;
      end
    end else if (w_rs2_hit) begin
      r_rs2_data <= i_phy_wr_data;
    end
  end

  assign o_rs1_ready = r_rs1_ready;
  assign o_rs2_held  = r_rs2_held;
  assign o_st_data   = r_rs2_data;

endmodule

// ==== design/stq_entry/stq_rob_monitor.sv ====
// ---------------------------------------------------------------------
// ROB side tracking: branch mask, flush detection and commit check
// ---------------------------------------------------------------------

module stq_rob_monitor (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_disp_load,
  input  lsu_tag_pkg::cmt_id_t         i_disp_cmt_id,
  input  lsu_tag_pkg::grp_id_t         i_disp_grp_id,
  input  lsu_tag_pkg::brmask_t         i_disp_br_mask,
  input  logic                         i_br_update,
  input  lsu_tag_pkg::brtag_t          i_br_tag,
  input  logic                         i_br_mispredict,
  input  logic                         i_commit_valid,
  input  lsu_tag_pkg::cmt_id_t         i_commit_cmt_id,
  input  lsu_tag_pkg::grp_id_t         i_commit_done_grp,
  input  logic                         i_commit_flush,
  input  stq_entry_pkg::stq_state_e    i_state,
  output logic                         o_flush,
  output logic                         o_disp_flush,
  output logic                         o_commit_ok
);

  import lsu_tag_pkg::*;
  import stq_entry_pkg::*;

  cmt_id_t r_cmt_id;
  grp_id_t r_grp_id;
  brmask_t r_br_mask;
  brmask_t w_resolved;
  grp_id_t w_older_grp;
  logic    w_live;

  assign w_resolved = i_br_update ? (brmask_t'(1) << i_br_tag) : '0;

  // live means dispatched and not yet committed
  assign w_live = (i_state != ST_INIT) & (i_state < ST_COMMIT);

  assign o_flush = w_live & (i_commit_flush |
                             i_br_update & i_br_mispredict & r_br_mask[i_br_tag]);

  assign o_disp_flush = i_disp_load & i_br_update & i_br_mispredict &
                        i_disp_br_mask[i_br_tag];

  // all older slots of the group must be done
  assign w_older_grp = r_grp_id - grp_id_t'(1);
  assign o_commit_ok = i_commit_valid & (i_commit_cmt_id == r_cmt_id) &
                       (i_state == ST_WAIT_COMMIT) &
                       ((i_commit_done_grp & w_older_grp) == w_older_grp);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_br_mask <= '0;
    end else begin
      r_br_mask <= (i_disp_load ? i_disp_br_mask : r_br_mask) & ~w_resolved;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_disp_load) begin
      r_cmt_id <= i_disp_cmt_id;
      r_grp_id <= i_disp_grp_id;
    end
  end

endmodule

// ==== design/stq_entry/stq_addr_capture.sv ====
// ---------------------------------------------------------------------
// address capture from EX1: address, size, uncached flag, exception
// ---------------------------------------------------------------------

module stq_addr_capture (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_ex1_accept,
  input  lsu_tag_pkg::addr_t         i_ex1_vaddr,
  input  lsu_tag_pkg::addr_t         i_ex1_paddr,
  input  stq_entry_pkg::st_size_t    i_ex1_size,
  input  logic                       i_ex1_uc,
  input  logic                       i_ex1_except,
  output lsu_tag_pkg::addr_t         o_st_addr,
  output stq_entry_pkg::st_size_t    o_st_size,
  output logic                       o_uc,
  output logic                       o_except
);

  // attribute flags steer the write-out request
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_uc     <= 1'b0;
      o_except <= 1'b0;
    end else if (i_ex1_accept) begin
      o_uc     <= i_ex1_uc;
      o_except <= i_ex1_except;
    end
  end

  // faulting address is reported as virtual
  always_ff @(posedge i_clk) begin
    if (i_ex1_accept) begin
      o_st_addr <= i_ex1_except ? i_ex1_vaddr : i_ex1_paddr;
      o_st_size <= i_ex1_size;
    end
  end

endmodule

// ==== common/stq_entry_pkg.sv ====
// ---------------------------------------------------------------------
// store-queue entry encodings: entry state, EX1 hazard code, store size
// ---------------------------------------------------------------------

package stq_entry_pkg;

  // ---------------------------------------------------------------------
  // entry lifecycle
  // ---------------------------------------------------------------------
  typedef enum logic [2:0] {
    ST_INIT         = 3'd0,
    ST_ISSUE_WAIT   = 3'd1,
    ST_ISSUED       = 3'd2,
    ST_WAIT_COMMIT  = 3'd3,
    ST_WAIT_ST_DATA = 3'd4,
    ST_COMMIT       = 3'd5,
    ST_DEAD         = 3'd6
  } stq_state_e;

  // result reported by the EX1 stage for an issued store
  typedef enum logic [1:0] {
    HAZ_NONE         = 2'd0,
    HAZ_TLB_MISS     = 2'd1,
    HAZ_L1D_CONFLICT = 2'd2
  } ex1_haz_e;

  // log2 of the byte count
  typedef logic [1:0] st_size_t;

endpackage

// ==== common/lsu_tag_pkg.sv ====
// ---------------------------------------------------------------------
// core-wide tag types shared by the load/store unit
// commit, group, rename and branch tags plus data and address widths
// ---------------------------------------------------------------------

package lsu_tag_pkg;

  // commit id of a retirement group
  localparam int CMT_ID_W = 6;
  typedef logic [CMT_ID_W-1:0] cmt_id_t;

  // one-hot slot inside a commit group
  localparam int GRP_W = 4;
  typedef logic [GRP_W-1:0] grp_id_t;

  // physical register rename id
  localparam int RNID_W = 7;
  typedef logic [RNID_W-1:0] rnid_t;

  // in-flight branch tracking
  localparam int BR_TAG_NUM = 8;
  typedef logic [$clog2(BR_TAG_NUM)-1:0] brtag_t;
  typedef logic [BR_TAG_NUM-1:0] brmask_t;

  // datapath widths
  localparam int XLEN = 64;
  typedef logic [XLEN-1:0] data_t;

  localparam int VADDR_W = 40;
  typedef logic [VADDR_W-1:0] addr_t;

endpackage
